/* rtl/fetch_defs.svh */
//////////////////////////////
// Fetch front end constants
// Reset PC, queue and memory sizes, and
// the NOP word for instruction registers
//////////////////////////////

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

// Queue entries, equal to the number of fetch credits
`define FETCH_QUEUE_DEPTH 4

// Credit counter width, holds 0 up to the queue depth
`define FETCH_CREDIT_W 3

// Instruction memory size in 32-bit words
`define FETCH_MEM_WORDS 256

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif

/* rtl/fetch_mem_pkg.sv */
//////////////////////////////
// Memory and queue payload types
// Request and response words of the memory
// ports, and the item held in the queue
//////////////////////////////

package fetch_mem_pkg;

    //////////////////////////////
    // Memory port
    //////////////////////////////

    // Request held by the master until granted
    typedef struct packed {
        logic        valid;
        logic        write;
        // Word address, not byte address
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // Read data, one cycle after the grant
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } mem_rsp_t;

    //////////////////////////////
    // Instruction queue
    //////////////////////////////

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        // First item of a new stream
        logic        redirect;
        // Redirect target had bit 1 set
        logic        misaligned;
    } fetch_item_t;

endpackage

/* rtl/fetch_ctrl_pkg.sv */
//////////////////////////////
// Fetch control encodings
// Arbiter owner and fetch unit FSM state
//////////////////////////////

package fetch_ctrl_pkg;

    //////////////////////////////
    // Arbiter
    //////////////////////////////

    // Port that owns the memory in a cycle, also tags
    // the response one cycle later
    typedef enum logic {
        OWNER_FETCH = 1'b0,
        OWNER_HOST  = 1'b1
    } port_owner_e;

    //////////////////////////////
    // Fetch unit
    //////////////////////////////

    // FS_FLUSH lasts one cycle while a stale response drains
    typedef enum logic [1:0] {
        FS_RUN       = 2'd0,
        FS_NO_CREDIT = 2'd1,
        FS_FLUSH     = 2'd2
    } fetch_state_e;

endpackage

/* rtl/fetch_unit.sv */
//////////////////////////////
// Fetch unit
// Keeps fetch address and PC, issues memory reads
// against queue credits, squashes stale responses
//////////////////////////////

`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetch_unit (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       redirect_i,
    input  logic [31:0]                redirect_target_i,
    output fetch_mem_pkg::mem_req_t    fetch_req_o,
    input  logic                       fetch_grant_i,
    input  fetch_mem_pkg::mem_rsp_t    fetch_rsp_i,
    input  logic                       credit_return_i,
    output logic                       push_o,
    output fetch_mem_pkg::fetch_item_t push_item_o
);
    import fetch_ctrl_pkg::*;

    localparam int unsigned DEPTH = `FETCH_QUEUE_DEPTH;

    logic [31:0]                fetch_addr_q;
    logic                       epoch_q;
    logic                       first_pending_q;
    logic                       mis_pending_q;
    logic [31:0]                inflight_pc_q;
    logic                       inflight_epoch_q;
    logic                       inflight_first_q;
    logic                       inflight_mis_q;
    logic [`FETCH_CREDIT_W-1:0] credit_q;
    logic [`FETCH_CREDIT_W-1:0] credit_d;
    logic                       drop;
    fetch_state_e               state_q;
    fetch_state_e               state_d;

    //////////////////////////////
    // Fetch address and redirect
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_addr_q    <= `FETCH_RESET_PC;
            epoch_q         <= 1'b0;
            first_pending_q <= 1'b0;
            mis_pending_q   <= 1'b0;
        end else if (redirect_i) begin
            fetch_addr_q    <= {redirect_target_i[31:2], 2'b00};
            epoch_q         <= ~epoch_q;
            first_pending_q <= 1'b1;
            mis_pending_q   <= redirect_target_i[1];
        end else if (fetch_grant_i) begin
            fetch_addr_q    <= fetch_addr_q + 32'd4;
            first_pending_q <= 1'b0;
            mis_pending_q   <= 1'b0;
        end
    end

    // Tag of the request in flight
    always_ff @(posedge clk) begin
        if (fetch_grant_i) begin
            inflight_pc_q    <= fetch_addr_q;
            inflight_epoch_q <= epoch_q;
            inflight_first_q <= first_pending_q;
            inflight_mis_q   <= mis_pending_q;
        end
    end

    always_comb begin
        fetch_req_o       = '0;
        fetch_req_o.valid = (state_q == FS_RUN);
        fetch_req_o.addr  = {2'b00, fetch_addr_q[31:2]};
    end

    //////////////////////////////
    // Response and queue push
    //////////////////////////////

    // Response of an older stream
    assign drop = fetch_rsp_i.valid && (inflight_epoch_q != epoch_q);
    assign push_o = fetch_rsp_i.valid && !drop;

    always_comb begin
        push_item_o.instr      = fetch_rsp_i.rdata;
        push_item_o.pc         = inflight_pc_q;
        push_item_o.redirect   = inflight_first_q;
        push_item_o.misaligned = inflight_mis_q;
    end

    //////////////////////////////
    // Credits and FSM
    //////////////////////////////

    // Spend on grant, regain on pop or on a dropped response
    always_comb begin
        credit_d = credit_q;
        if (fetch_grant_i)
            credit_d = credit_d - 1'b1;
        if (credit_return_i)
            credit_d = credit_d + 1'b1;
        if (drop)
            credit_d = credit_d + 1'b1;
    end

    always_comb begin
        if (redirect_i && fetch_grant_i)
            state_d = FS_FLUSH;
        else if (credit_d == '0)
            state_d = FS_NO_CREDIT;
        else
            state_d = FS_RUN;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_q <= DEPTH[`FETCH_CREDIT_W-1:0];
            state_q  <= FS_RUN;
        end else begin
            credit_q <= credit_d;
            state_q  <= state_d;
        end
    end

    // Credits plus queued and in-flight items stay at the depth
    a_credit_max: assert property (@(posedge clk) disable iff (!reset_n)
        credit_q <= DEPTH);

endmodule

/* rtl/mem_arbiter.sv */
//////////////////////////////
// Memory arbiter
// Round-robin between fetch and host ports,
// routes read data back to the owner
//////////////////////////////

`timescale 1ns/100ps

module mem_arbiter (
    input  logic                    clk,
    input  logic                    reset_n,
    input  fetch_mem_pkg::mem_req_t fetch_req_i,
    output logic                    fetch_grant_o,
    output fetch_mem_pkg::mem_rsp_t fetch_rsp_o,
    input  fetch_mem_pkg::mem_req_t host_req_i,
    output logic                    host_grant_o,
    output fetch_mem_pkg::mem_rsp_t host_rsp_o,
    output fetch_mem_pkg::mem_req_t mem_req_o,
    input  fetch_mem_pkg::mem_rsp_t mem_rsp_i
);
    import fetch_ctrl_pkg::*;

    port_owner_e last_owner_q;
    port_owner_e rsp_owner_q;
    logic        pick_host;

    // On conflict the port not granted last time wins
    always_comb begin
        if (fetch_req_i.valid && host_req_i.valid)
            pick_host = (last_owner_q == OWNER_FETCH);
        else
            pick_host = host_req_i.valid;
    end

    assign host_grant_o  = host_req_i.valid && pick_host;
    assign fetch_grant_o = fetch_req_i.valid && !pick_host;

    always_comb begin
        if (host_grant_o)
            mem_req_o = host_req_i;
        else if (fetch_grant_o)
            mem_req_o = fetch_req_i;
        else
            mem_req_o = '0;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_owner_q <= OWNER_HOST;
            rsp_owner_q  <= OWNER_FETCH;
        end else begin
            rsp_owner_q <= pick_host ? OWNER_HOST : OWNER_FETCH;
            if (host_grant_o || fetch_grant_o)
                last_owner_q <= pick_host ? OWNER_HOST : OWNER_FETCH;
        end
    end

    // Response goes to the owner of last cycle's grant
    always_comb begin
        fetch_rsp_o.rdata = mem_rsp_i.rdata;
        fetch_rsp_o.valid = mem_rsp_i.valid && (rsp_owner_q == OWNER_FETCH);
        host_rsp_o.rdata  = mem_rsp_i.rdata;
        host_rsp_o.valid  = mem_rsp_i.valid && (rsp_owner_q == OWNER_HOST);
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!reset_n)
        !(fetch_grant_o && host_grant_o));

    // Memory answers only what was granted the cycle before
    a_rsp_follows_grant: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rsp_i.valid |-> $past(fetch_grant_o || host_grant_o));

endmodule

/* rtl/imem.sv */
//////////////////////////////
// Instruction memory
// Single port, one-cycle read latency
//////////////////////////////

`timescale 1ns/100ps
`include "fetch_defs.svh"

module imem (
    input  logic                    clk,
    input  logic                    reset_n,
    input  fetch_mem_pkg::mem_req_t mem_req_i,
    output fetch_mem_pkg::mem_rsp_t mem_rsp_o
);

    localparam int unsigned WORDS = `FETCH_MEM_WORDS;
    localparam int unsigned IDX_W = $clog2(WORDS);

    logic [31:0]      mem_q [WORDS];
    logic [IDX_W-1:0] idx;
    logic             rd_en;
    logic             rd_valid_q;
    logic [31:0]      rd_data_q;

    // Upper word address bits wrap onto the array
    assign idx   = mem_req_i.addr[IDX_W-1:0];
    assign rd_en = mem_req_i.valid && !mem_req_i.write;

    always_ff @(posedge clk) begin
        if (mem_req_i.valid && mem_req_i.write)
            mem_q[idx] <= mem_req_i.wdata;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_q <= 1'b0;
            rd_data_q  <= `FETCH_NOP;
        end else begin
            rd_valid_q <= rd_en;
            if (rd_en)
                rd_data_q <= mem_q[idx];
        end
    end

    always_comb begin
        mem_rsp_o.valid = rd_valid_q;
        mem_rsp_o.rdata = rd_data_q;
    end

endmodule

/* rtl/instr_queue.sv */
//////////////////////////////
// Instruction queue
// Circular FIFO of fetch items, each pop
// hands a credit back to the fetch unit
//////////////////////////////

`timescale 1ns/100ps
`include "fetch_defs.svh"

module instr_queue (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       push_i,
    input  fetch_mem_pkg::fetch_item_t push_item_i,
    input  logic                       pop_i,
    output logic                       item_valid_o,
    output fetch_mem_pkg::fetch_item_t item_o,
    output logic                       credit_return_o
);
    import fetch_mem_pkg::*;

    localparam int unsigned DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    fetch_item_t                entries [DEPTH];
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [`FETCH_CREDIT_W-1:0] count_q;
    logic                       pop_ok;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign item_valid_o    = (count_q != '0);
    assign item_o          = entries[rd_ptr_q];
    assign pop_ok          = pop_i && item_valid_o;
    assign credit_return_o = pop_ok;

    // Space is guaranteed by credits
    always_ff @(posedge clk) begin
        if (push_i)
            entries[wr_ptr_q] <= push_item_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop_ok)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            if (push_i && !pop_ok)
                count_q <= count_q + 1'b1;
            else if (pop_ok && !push_i)
                count_q <= count_q - 1'b1;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
        push_i |-> (count_q != DEPTH));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
        pop_i |-> (count_q != '0));

endmodule

/* rtl/fetch_top.sv */
//////////////////////////////
// Fetch front end top level
// Fetch unit, arbiter, memory and queue
//////////////////////////////

`timescale 1ns/100ps

module fetch_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       redirect_i,
    input  logic [31:0]                redirect_target_i,
    input  fetch_mem_pkg::mem_req_t    host_req_i,
    output logic                       host_grant_o,
    output fetch_mem_pkg::mem_rsp_t    host_rsp_o,
    input  logic                       pop_i,
    output logic                       item_valid_o,
    output fetch_mem_pkg::fetch_item_t item_o
);
    import fetch_mem_pkg::*;

    mem_req_t    fetch_req;
    logic        fetch_grant;
    mem_rsp_t    fetch_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic        push;
    fetch_item_t push_item;
    logic        credit_return;

    fetch_unit i_fetch_unit (
        .clk               (clk),
        .reset_n           (reset_n),
        .redirect_i        (redirect_i),
        .redirect_target_i (redirect_target_i),
        .fetch_req_o       (fetch_req),
        .fetch_grant_i     (fetch_grant),
        .fetch_rsp_i       (fetch_rsp),
        .credit_return_i   (credit_return),
        .push_o            (push),
        .push_item_o       (push_item)
    );

    mem_arbiter i_mem_arbiter (
        .clk           (clk),
        .reset_n       (reset_n),
        .fetch_req_i   (fetch_req),
        .fetch_grant_o (fetch_grant),
        .fetch_rsp_o   (fetch_rsp),
        .host_req_i    (host_req_i),
        .host_grant_o  (host_grant_o),
        .host_rsp_o    (host_rsp_o),
        .mem_req_o     (mem_req),
        .mem_rsp_i     (mem_rsp)
    );

    imem i_imem (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    instr_queue i_instr_queue (
        .clk             (clk),
        .reset_n         (reset_n),
        .push_i          (push),
        .push_item_i     (push_item),
        .pop_i           (pop_i),
        .item_valid_o    (item_valid_o),
        .item_o          (item_o),
        .credit_return_o (credit_return)
    );

endmodule

/* tb/tb_fetch.sv */
//////////////////////////////
// Fetch front end testbench
// Replays the command file, checks host
// readback and every popped fetch item
//////////////////////////////

`timescale 1ns/100ps
`include "fetch_defs.svh"

module tb_fetch;
    import fetch_mem_pkg::*;

    localparam int MAX_CMDS  = 64;
    localparam int MEM_WORDS = `FETCH_MEM_WORDS;

    logic        clk;
    logic        reset_n;
    logic        redirect;
    logic [31:0] redirect_target;
    mem_req_t    host_req;
    logic        host_grant;
    mem_rsp_t    host_rsp;
    logic        pop;
    logic        item_valid;
    fetch_item_t item;

    logic [31:0] cmds [3*MAX_CMDS];
    // Reference image of the instruction memory
    logic [31:0] img [MEM_WORDS];
    logic [31:0] rnd;
    logic [31:0] exp_pc;
    logic [31:0] redir_target;
    logic        synced;
    logic        redir_pending;
    logic        seen_full;
    int          pop_mode;
    int          n_cmds;
    int          n_tests;
    int          n_checks;
    int          n_errors;
    int          n_items;

    fetch_top i_dut (
        .clk               (clk),
        .reset_n           (reset_n),
        .redirect_i        (redirect),
        .redirect_target_i (redirect_target),
        .host_req_i        (host_req),
        .host_grant_o      (host_grant),
        .host_rsp_o        (host_rsp),
        .pop_i             (pop),
        .item_valid_o      (item_valid),
        .item_o            (item)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fill pattern over the full byte address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0013;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        n_errors++;
        $display("failure at %0d ns: %s", $time, msg);
    endtask

    //////////////////////////////
    // Host port and redirect
    //////////////////////////////

    task automatic host_access(input logic wr, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int   waited;
        logic granted;
        waited = 0;
        rdata = '0;
        @(negedge clk);
        host_req.valid = 1'b1;
        host_req.write = wr;
        host_req.addr  = addr >> 2;
        host_req.wdata = wdata;
        #1;
        while (!host_grant && waited < 16) begin
            @(negedge clk);
            #1;
            waited++;
        end
        granted = host_grant;
        if (!granted)
            report_failure("host request got no grant within 16 cycles");
        else if (wr)
            img[(addr >> 2) % MEM_WORDS] = wdata;
        @(negedge clk);
        host_req = '0;
        if (granted && !wr) begin
            #1;
            if (!host_rsp.valid)
                report_failure("host read response missing one cycle after the grant");
            rdata = host_rsp.rdata;
        end
    endtask

    task automatic apply_redirect(input logic [31:0] target);
        @(negedge clk);
        redir_target    = target;
        redir_pending   = 1'b1;
        redirect        = 1'b1;
        redirect_target = target;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    //////////////////////////////
    // Consumer and stream model
    //////////////////////////////

    task automatic check_item(input fetch_item_t it);
        if (it.redirect) begin
            if (!redir_pending) begin
                report_failure("item carries the redirect flag with no redirect pending");
            end else begin
                check_value("item_o.pc", it.pc, {redir_target[31:2], 2'b00});
                check_value("item_o.misaligned", 32'(it.misaligned), 32'(redir_target[1]));
                exp_pc        = {redir_target[31:2], 2'b00};
                redir_pending = 1'b0;
                synced        = 1'b1;
            end
        end else if (synced) begin
            // Old stream continues until the flagged item
            check_value("item_o.pc", it.pc, exp_pc);
            check_value("item_o.misaligned", 32'(it.misaligned), 32'd0);
        end
        if (synced) begin
            check_value("item_o.instr", it.instr, img[(exp_pc >> 2) % MEM_WORDS]);
            exp_pc = exp_pc + 32'd4;
            n_items++;
        end
    endtask

    always @(negedge clk) begin : consumer
        logic take;
        if (!reset_n) begin
            pop = 1'b0;
        end else begin
            rnd  = xorshift(rnd);
            take = item_valid && (pop_mode == 0 || (pop_mode == 1 && rnd[1:0] != 2'b00));
            if (pop_mode == 2 && seen_full && !item_valid)
                report_failure("item_valid_o dropped while pops were stopped");
            seen_full = (pop_mode == 2) && (seen_full || item_valid);
            if (int'(i_dut.i_instr_queue.count_q) > `FETCH_QUEUE_DEPTH)
                report_failure("queue holds more items than its depth");
            pop = take;
            if (take)
                check_item(item);
        end
    end

    //////////////////////////////
    // Command sequencer
    //////////////////////////////

    initial begin
        logic [31:0] op;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] rdata;
        int          last_errors;
        reset_n = 1'b0;
        redirect = 1'b0;
        redirect_target = '0;
        host_req = '0;
        pop = 1'b0;
        rnd = 32'h2359;
        exp_pc = `FETCH_RESET_PC;
        redir_target = '0;
        synced = 1'b0;
        redir_pending = 1'b0;
        seen_full = 1'b0;
        pop_mode = 2;
        n_tests = 0;
        n_checks = 0;
        n_errors = 0;
        n_items = 0;
        last_errors = 0;
        for (int i = 0; i < 3*MAX_CMDS; i++)
            cmds[i] = '0;
        $readmemh("tb/fetch_testdata.txt", cmds);
        n_cmds = 0;
        while (n_cmds < MAX_CMDS && cmds[3*n_cmds] != '0)
            n_cmds++;
        if (n_cmds == 0)
            report_failure("no commands read from tb/fetch_testdata.txt");
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (int c = 0; c < n_cmds; c++) begin
            op = cmds[3*c];
            a0 = cmds[3*c+1];
            a1 = cmds[3*c+2];
            case (op)
                32'd1: host_access(1'b1, a0, a1, rdata);
                32'd2: begin
                    host_access(1'b0, a0, '0, rdata);
                    check_value("host_rsp_o.rdata", rdata, a1);
                end
                32'd3: begin
                    for (int w = 0; w < int'(a1); w++)
                        host_access(1'b1, a0 + 4*w, fill_word(a0 + 4*w), rdata);
                end
                // Fresh stream from the reset PC, earlier items are discarded
                32'd4: apply_redirect(`FETCH_RESET_PC);
                32'd5: begin
                    @(posedge clk);
                    pop_mode = int'(a1);
                    repeat (int'(a0)) @(negedge clk);
                end
                32'd6: apply_redirect(a0);
                32'd7: begin
                    @(posedge clk);
                    if (redir_pending)
                        report_failure("flagged item of the last redirect never arrived");
                    n_tests++;
                    $display("test %0d finished with %0d errors", a0, n_errors - last_errors);
                    last_errors = n_errors;
                end
                default: report_failure("unknown opcode in the test data");
            endcase
        end
        $display("tests %0d, items %0d, checks %0d, errors %0d",
                 n_tests, n_items, n_checks, n_errors);
        if (n_errors == 0 && n_checks > 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // Budget of 200 cycles per command line
    initial begin : watchdog
        #1;
        repeat ((n_cmds + 1) * 200) @(posedge clk);
        $display("timeout after %0d cycles, the command sequence did not finish",
                 (n_cmds + 1) * 200);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* tb/fetch_testdata.txt */
// Columns in hex: opcode arg0 arg1. 1 write addr data, 2 read addr expected, 3 fill addr words,
// 4 go, 5 run cycles popmode (0 every cycle, 1 random, 2 stopped), 6 redirect target, 7 end test
3 00000000 00000100
1 00000200 deadbeef
2 00000200 deadbeef
2 000003fc 5a5a03ef
7 00000001 00000000
4 00000000 00000000
5 0000003c 00000000
7 00000002 00000000
5 00000028 00000002
5 00000050 00000001
7 00000003 00000000
6 00000100 00000000
5 0000003c 00000001
7 00000004 00000000
6 00000242 00000000
5 00000028 00000000
7 00000005 00000000
6 00000300 00000000
5 00000008 00000001
1 000003c0 00000113
1 000003c4 00100093
2 000003c4 00100093
5 00000080 00000001
7 00000006 00000000

/* flist.f */
+incdir+rtl
rtl/fetch_mem_pkg.sv
rtl/fetch_ctrl_pkg.sv
rtl/fetch_unit.sv
rtl/mem_arbiter.sv
rtl/imem.sv
rtl/instr_queue.sv
rtl/fetch_top.sv
tb/tb_fetch.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= tb_fetch
FLIST     ?= flist.f

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)
LOG     := sim.log

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM) tb/fetch_testdata.txt
	./$(SIM) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
